//--- files.f
+incdir+tests
src/mem_bus_pkg.sv
src/lsu_op_pkg.sv
src/serial_addr_gen.sv
src/serial_mem_if.sv
src/data_ram.sv
src/lsu_top.sv
tests/lsu_tb.sv

//--- run.sh
#!/bin/sh
# Build the LSU testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns \
   -f files.f --top-module lsu_tb -o lsu_sim

./obj_dir/lsu_sim | tee sim.log

if grep -qx "Testbench passed" sim.log; then
   exit 0
fi
exit 1

//--- src/data_ram.sv
`timescale 1ns/1ns
`default_nettype none

module data_ram #(
   parameter int RAM_WORDS    = 256,
   parameter int READ_LATENCY = 3
) (
   input  wire logic               i_clk,
   input  wire logic               i_reset,
   // Command channel
   input  wire logic               i_ca_cmd,
   input  wire mem_bus_pkg::addr_t i_ca_adr,
   input  wire logic               i_ca_vld,
   output logic                    o_ca_rdy,
   // Write-data channel
   input  wire mem_bus_pkg::data_t i_dm_dat,
   input  wire mem_bus_pkg::mask_t i_dm_msk,
   input  wire logic               i_dm_vld,
   output logic                    o_dm_rdy,
   // Read-response channel
   output mem_bus_pkg::data_t      o_rd_dat,
   output logic                    o_rd_vld,
   input  wire logic               i_rd_rdy
);

   import mem_bus_pkg::*;

   localparam int IDX_W    = (RAM_WORDS > 1) ? $clog2(RAM_WORDS) : 1;
   localparam int CNT_W    = (READ_LATENCY > 2) ? $clog2(READ_LATENCY - 1) : 1;
   localparam int CNT_LOAD = (READ_LATENCY > 2) ? READ_LATENCY - 2 : 0;

   data_t            mem [RAM_WORDS];
   ram_state_t       state;
   logic [IDX_W-1:0] idx_r;
   logic [IDX_W-1:0] ca_idx;
   logic [IDX_W-1:0] rd_idx;
   logic [CNT_W-1:0] cnt;
   logic             ca_en;
   logic             dm_en;
   logic             rd_en;
   logic             fetch;

   assign o_ca_rdy = (state == RAM_IDLE);
   assign o_dm_rdy = (state == RAM_WR_WAIT);
   assign o_rd_vld = (state == RAM_RD_RESP);

   assign ca_en = i_ca_vld & o_ca_rdy;
   assign dm_en = i_dm_vld & o_dm_rdy;
   assign rd_en = o_rd_vld & i_rd_rdy;

   assign ca_idx = IDX_W'(i_ca_adr[31:2] % RAM_WORDS);  // Wraps at the depth
   assign rd_idx = (state == RAM_IDLE) ? ca_idx : idx_r;

   // The word is read in the cycle before the response goes valid
   assign fetch = (ca_en && !i_ca_cmd && READ_LATENCY == 1) ||
                  (state == RAM_RD_DELAY && cnt == '0);

   // *******************************************************************
   // Controller

   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         state <= RAM_IDLE;
         cnt   <= '0;
      end else begin
         case (state)
            RAM_IDLE: begin
               if (ca_en) begin
                  if (i_ca_cmd) begin
                     state <= RAM_WR_WAIT;
                  end else if (READ_LATENCY == 1) begin
                     state <= RAM_RD_RESP;
                  end else begin
                     state <= RAM_RD_DELAY;
                     cnt   <= CNT_W'(CNT_LOAD);
                  end
               end
            end
            RAM_WR_WAIT: begin
               if (dm_en)
                  state <= RAM_IDLE;
            end
            RAM_RD_DELAY: begin
               if (cnt == '0)
                  state <= RAM_RD_RESP;
               else
                  cnt <= cnt - 1'b1;
            end
            RAM_RD_RESP: begin
               if (rd_en)
                  state <= RAM_IDLE;  // Held here while the core stalls
            end
            default: state <= RAM_IDLE;
         endcase
      end
   end

   // *******************************************************************
   // Storage

   always_ff @(posedge i_clk) begin
      if (ca_en)
         idx_r <= ca_idx;
      if (fetch)
         o_rd_dat <= mem[rd_idx];
      if (dm_en) begin
         for (int i = 0; i < LANES; i++) begin
            if (i_dm_msk[i])
               mem[idx_r][8*i +: 8] <= i_dm_dat[8*i +: 8];
         end
      end
   end

endmodule

`default_nettype wire

//--- src/lsu_op_pkg.sv
`default_nettype none

package lsu_op_pkg;

   // LB LH LW LBU LHU on loads, SB SH SW on stores
   typedef logic [2:0] funct3_t;

   // Access size, the low two bits of funct3
   typedef logic [1:0] size_t;

   localparam size_t SIZE_BYTE = 2'b00;
   localparam size_t SIZE_HALF = 2'b01;
   // Word accesses use 2'b10 and take the default paths

   // Set in funct3 means zero extension on a load
   localparam int UNSIGNED_BIT = 2;

   // Value of the command bit for a store
   localparam logic CMD_STORE = 1'b1;

endpackage

`default_nettype wire

//--- src/lsu_top.sv
`timescale 1ns/1ns
`default_nettype none

module lsu_top #(
   parameter int RAM_WORDS    = 256,
   parameter int READ_LATENCY = 3
) (
   input  wire logic                i_clk,
   input  wire logic                i_reset,
   input  wire logic                i_en,
   input  wire logic                i_init,
   input  wire logic                i_dat_valid,
   input  wire logic                i_cmd,
   input  wire logic                i_rs1,
   input  wire logic                i_rs2,
   input  wire logic                i_imm,
   input  wire lsu_op_pkg::funct3_t i_funct3,
   output logic                     o_rd,
   output logic                     o_busy
);

   import mem_bus_pkg::*;

   addr_t adr;

   // Memory bus between the bridge and the RAM
   logic  ca_cmd;
   addr_t ca_adr;
   logic  ca_vld;
   logic  ca_rdy;
   data_t dm_dat;
   mask_t dm_msk;
   logic  dm_vld;
   logic  dm_rdy;
   data_t rd_dat;
   logic  rd_vld;
   logic  rd_rdy;

   serial_addr_gen addr_gen_i (
      .i_clk (i_clk),
      .i_en  (i_en),
      .i_rs1 (i_rs1),
      .i_imm (i_imm),
      .o_adr (adr)
   );

   serial_mem_if mem_if_i (
      .i_clk       (i_clk),
      .i_reset     (i_reset),
      .i_en        (i_en),
      .i_init      (i_init),
      .i_dat_valid (i_dat_valid),
      .i_cmd       (i_cmd),
      .i_funct3    (i_funct3),
      .i_rs2       (i_rs2),
      .i_adr       (adr),
      .o_rd        (o_rd),
      .o_busy      (o_busy),
      .o_ca_cmd    (ca_cmd),
      .o_ca_adr    (ca_adr),
      .o_ca_vld    (ca_vld),
      .i_ca_rdy    (ca_rdy),
      .o_dm_dat    (dm_dat),
      .o_dm_msk    (dm_msk),
      .o_dm_vld    (dm_vld),
      .i_dm_rdy    (dm_rdy),
      .i_rd_dat    (rd_dat),
      .i_rd_vld    (rd_vld),
      .o_rd_rdy    (rd_rdy)
   );

   data_ram #(
      .RAM_WORDS    (RAM_WORDS),
      .READ_LATENCY (READ_LATENCY)
   ) ram_i (
      .i_clk    (i_clk),
      .i_reset  (i_reset),
      .i_ca_cmd (ca_cmd),
      .i_ca_adr (ca_adr),
      .i_ca_vld (ca_vld),
      .o_ca_rdy (ca_rdy),
      .i_dm_dat (dm_dat),
      .i_dm_msk (dm_msk),
      .i_dm_vld (dm_vld),
      .o_dm_rdy (dm_rdy),
      .o_rd_dat (rd_dat),
      .o_rd_vld (rd_vld),
      .i_rd_rdy (rd_rdy)
   );

endmodule

`default_nettype wire

//--- src/mem_bus_pkg.sv
`default_nettype none

package mem_bus_pkg;

   localparam int DATA_W = 32;
   localparam int LANES  = DATA_W / 8;

   typedef logic [DATA_W-1:0]        data_t;  // One word on the memory bus
   typedef logic [31:0]              addr_t;  // Byte address
   typedef logic [LANES-1:0]         mask_t;  // Byte lane write enables
   typedef logic [$clog2(LANES)-1:0] lane_t;  // Byte position within a word

   typedef enum logic [1:0] {
      RAM_IDLE,
      RAM_WR_WAIT,
      RAM_RD_DELAY,
      RAM_RD_RESP
   } ram_state_t;

endpackage

`default_nettype wire

//--- src/serial_addr_gen.sv
`timescale 1ns/1ns
`default_nettype none

module serial_addr_gen (
   input  wire logic          i_clk,
   input  wire logic          i_en,
   input  wire logic          i_rs1,
   input  wire logic          i_imm,
   output mem_bus_pkg::addr_t o_adr
);

   logic carry;
   logic sum;
   logic carry_nxt;

   // *******************************************************************
   // One-bit full adder, LSB first

   assign sum       = i_rs1 ^ i_imm ^ carry;
   assign carry_nxt = (i_rs1 & i_imm) | (carry & (i_rs1 ^ i_imm));

   always_ff @(posedge i_clk) begin
      if (i_en)
         carry <= carry_nxt;
      else
         carry <= 1'b0;  // Every phase starts with zero carry
   end

   // *******************************************************************
   // Address shift register

   // Sum bits enter at the top and walk down, so after 32 enabled cycles
   // bit 0 of the sum sits at bit 0 of the register
   always_ff @(posedge i_clk) begin
      if (i_en)
         o_adr <= {sum, o_adr[31:1]};
   end

   // The register holds its value while i_en is low, which keeps the
   // command address steady for the memory side until it is taken

endmodule

`default_nettype wire

//--- src/serial_mem_if.sv
`timescale 1ns/1ns
`default_nettype none

module serial_mem_if (
   input  wire logic                i_clk,
   input  wire logic                i_reset,
   input  wire logic                i_en,
   input  wire logic                i_init,
   input  wire logic                i_dat_valid,
   input  wire logic                i_cmd,
   input  wire lsu_op_pkg::funct3_t i_funct3,
   input  wire logic                i_rs2,
   input  wire mem_bus_pkg::addr_t  i_adr,
   output logic                     o_rd,
   output logic                     o_busy,
   // Command channel
   output logic                     o_ca_cmd,
   output mem_bus_pkg::addr_t       o_ca_adr,
   output logic                     o_ca_vld,
   input  wire logic                i_ca_rdy,
   // Write-data channel
   output mem_bus_pkg::data_t       o_dm_dat,
   output mem_bus_pkg::mask_t       o_dm_msk,
   output logic                     o_dm_vld,
   input  wire logic                i_dm_rdy,
   // Read-response channel
   input  wire mem_bus_pkg::data_t  i_rd_dat,
   input  wire logic                i_rd_vld,
   output logic                     o_rd_rdy
);

   import mem_bus_pkg::*;
   import lsu_op_pkg::*;

   logic       ca_en;
   logic       dm_en;
   logic       rd_en;
   logic       init_r;    // Last cycle was an init cycle
   logic       signbit;
   logic       issue;
   data_t      dat;
   size_t      size;
   lane_t      lane;
   logic [4:0] ld_shift;

   assign ca_en = o_ca_vld & i_ca_rdy;
   assign dm_en = o_dm_vld & i_dm_rdy;
   assign rd_en = i_rd_vld & o_rd_rdy;

   assign size  = i_funct3[1:0];
   assign lane  = i_adr[1:0];
   assign issue = init_r & ~i_en;  // Falling enable at the end of init

   assign o_ca_cmd = i_cmd;
   assign o_ca_adr = i_adr;
   assign o_rd_rdy = ~i_en;

   // Past the valid width the output repeats the sign or gives zero
   assign o_rd = i_dat_valid ? dat[0] : (signbit & ~i_funct3[UNSIGNED_BIT]);

   // *******************************************************************
   // Store lane placement, byte mask and load shift amount

   always_comb begin
      o_dm_dat = dat;
      o_dm_msk = '1;
      ld_shift = 5'd0;
      case (size)
         SIZE_BYTE: begin
            o_dm_dat = {4{dat[7:0]}};
            o_dm_msk = mask_t'(4'b0001 << lane);
            ld_shift = {lane, 3'b000};
         end
         SIZE_HALF: begin
            o_dm_dat = {2{dat[15:0]}};
            o_dm_msk = lane[1] ? 4'b1100 : 4'b0011;
            ld_shift = {lane[1], 4'b0000};
         end
         default: ;
      endcase
   end

   // *******************************************************************
   // Control

   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         init_r   <= 1'b0;
         o_busy   <= 1'b0;
         o_ca_vld <= 1'b0;
         o_dm_vld <= 1'b0;
         signbit  <= 1'b0;
      end else begin
         init_r <= i_en & i_init;

         if (i_en & i_init)
            o_busy <= 1'b1;
         else if (rd_en | dm_en)
            o_busy <= 1'b0;

         if (ca_en)
            o_ca_vld <= 1'b0;
         else if (issue)
            o_ca_vld <= 1'b1;

         if (dm_en)
            o_dm_vld <= 1'b0;
         else if (issue)
            o_dm_vld <= (i_cmd == CMD_STORE);

         if (i_en & i_init)
            signbit <= 1'b0;
         else if (i_en & i_dat_valid)
            signbit <= dat[0];  // Ends up as the top bit of the loaded field
      end
   end

   // Store data shifts in during init, load data shifts out afterwards
   always_ff @(posedge i_clk) begin
      if (rd_en)
         dat <= i_rd_dat >> ld_shift;
      else if (i_en)
         dat <= {i_rs2, dat[31:1]};
   end

   // *******************************************************************
   // Bus protocol checks

   ca_hold: assert property (@(posedge i_clk) disable iff (i_reset)
      o_ca_vld && !i_ca_rdy |=> o_ca_vld && $stable(o_ca_adr));

   dm_hold: assert property (@(posedge i_clk) disable iff (i_reset)
      o_dm_vld && !i_dm_rdy |=> o_dm_vld && $stable(o_dm_dat) && $stable(o_dm_msk));

   dm_store_only: assert property (@(posedge i_clk) disable iff (i_reset)
      o_dm_vld |-> i_cmd == CMD_STORE);

endmodule

`default_nettype wire

//--- tests/lsu_tb_tasks.svh
`ifndef LSU_TB_TASKS_SVH
`define LSU_TB_TASKS_SVH

// *******************************************************************
// Result checks

task automatic compare_word(input string name, input data_t got, input data_t exp);
   if (got !== exp) begin
      error_count++;
      $display("Mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp);
   end
endtask

task automatic compare_bit(input string name, input logic got, input logic exp);
   if (got !== exp) begin
      error_count++;
      $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
   end
endtask

// Number of loaded bits that carry data, from the size field
function automatic int field_width(input funct3_t f3);
   case (f3[1:0])
      2'b00:   return 8;
      2'b01:   return 16;
      default: return 32;
   endcase
endfunction

// *******************************************************************
// Serial drive and capture

task automatic shift_operands(input op_rec_t rec);
   for (int k = 0; k < 32; k++) begin
      @(negedge i_clk);
      i_en     = 1'b1;
      i_init   = 1'b1;
      i_cmd    = rec.is_store;
      i_funct3 = rec.f3;
      i_rs1    = rec.rs1[k];  // LSB first
      i_imm    = rec.imm[k];
      i_rs2    = rec.rs2[k];
   end
   @(negedge i_clk);
   i_en   = 1'b0;  // Falling enable issues the command
   i_init = 1'b0;
   i_rs1  = 1'b0;
   i_imm  = 1'b0;
   i_rs2  = 1'b0;
endtask

task automatic wait_not_busy();
   int cycles;
   cycles = 0;
   while (o_busy !== 1'b0) begin
      if (cycles == BUSY_LIMIT) begin
         error_count++;
         $display("o_busy stayed high for %0d cycles after the command was issued", cycles);
         break;
      end
      @(negedge i_clk);
      cycles++;
   end
endtask

task automatic read_result(input int width, output data_t value);
   for (int k = 0; k < 32; k++) begin
      @(negedge i_clk);
      i_en        = 1'b1;
      i_dat_valid = (k < width);
      #(CLK_PERIOD / 4);  // o_rd settles in the low phase
      value[k] = o_rd;
   end
   @(negedge i_clk);
   i_en        = 1'b0;
   i_dat_valid = 1'b0;
endtask

`endif

//--- tests/lsu_tb.sv
`timescale 1ns/1ns
`default_nettype none

module lsu_tb;

   import mem_bus_pkg::*;
   import lsu_op_pkg::*;

   localparam int CLK_PERIOD   = 10;
   localparam int RESET_CYCLES = 16;
   localparam int READ_LATENCY = 3;
   localparam int OP_CYCLES    = 80 + READ_LATENCY;  // Bound on one record
   localparam int BUSY_LIMIT   = 8 + READ_LATENCY;

   typedef struct packed {
      logic    is_store;
      funct3_t f3;
      data_t   rs1;
      data_t   imm;
      data_t   rs2;
      data_t   expected;
   } op_rec_t;

   logic    i_clk = 1'b0;
   logic    i_reset;
   logic    i_en;
   logic    i_init;
   logic    i_dat_valid;
   logic    i_cmd;
   logic    i_rs1;
   logic    i_rs2;
   logic    i_imm;
   funct3_t i_funct3;
   logic    o_rd;
   logic    o_busy;

   op_rec_t records[$];
   bit      records_loaded;
   int      error_count;
   int      pass_count;
   int      fail_count;

   `include "lsu_tb_tasks.svh"

   lsu_top #(
      .READ_LATENCY (READ_LATENCY)
   ) dut_i (
      .i_clk       (i_clk),
      .i_reset     (i_reset),
      .i_en        (i_en),
      .i_init      (i_init),
      .i_dat_valid (i_dat_valid),
      .i_cmd       (i_cmd),
      .i_rs1       (i_rs1),
      .i_rs2       (i_rs2),
      .i_imm       (i_imm),
      .i_funct3    (i_funct3),
      .o_rd        (o_rd),
      .o_busy      (o_busy)
   );

   always #(CLK_PERIOD / 2) i_clk = ~i_clk;

   task automatic load_records();
      int          fd;
      string       line;
      logic [31:0] op, f3, rs1, imm, rs2, exp;
      fd = $fopen("tests/lsu_testdata.txt", "r");
      if (fd == 0) begin
         $display("Cannot open the data file tests/lsu_testdata.txt");
         return;
      end
      while (!$feof(fd)) begin
         if ($fgets(line, fd) == 0)
            break;
         if ($sscanf(line, "%h %h %h %h %h %h", op, f3, rs1, imm, rs2, exp) == 6)
            records.push_back({op[0], funct3_t'(f3), rs1, imm, rs2, exp});  // Comments skip
      end
      $fclose(fd);
   endtask

   function automatic string describe(input op_rec_t rec);
      return $sformatf("%s funct3=%0d rs1=%08h imm=%08h",
                       rec.is_store ? "store" : "load", rec.f3, rec.rs1, rec.imm);
   endfunction

   task automatic close_test(input int num, input string what, input int errors_before);
      if (error_count == errors_before) begin
         pass_count++;
         $display("Test %0d %s: ok", num, what);
      end else begin
         fail_count++;
         $display("Test %0d %s: FAILED", num, what);
      end
   endtask

   // *******************************************************************
   // Main sequence

   initial begin
      op_rec_t rec;
      int      errors_before;
      data_t   result;
      i_reset     = 1'b1;
      i_en        = 1'b0;
      i_init      = 1'b0;
      i_dat_valid = 1'b0;
      i_cmd       = 1'b0;
      i_rs1       = 1'b0;
      i_rs2       = 1'b0;
      i_imm       = 1'b0;
      i_funct3    = '0;
      load_records();
      records_loaded = 1'b1;
      if (records.size() == 0) begin
         $display("No operation records were read from the data file");
         fail_count++;
      end

      repeat (RESET_CYCLES) @(posedge i_clk);
      @(negedge i_clk);
      i_reset = 1'b0;
      @(negedge i_clk);
      errors_before = error_count;
      compare_bit("o_busy", o_busy, 1'b0);
      compare_bit("o_rd", o_rd, 1'b0);
      close_test(0, "reset state", errors_before);

      foreach (records[i]) begin
         rec           = records[i];
         errors_before = error_count;
         shift_operands(rec);
         compare_bit("o_busy", o_busy, 1'b1);  // Raised during init
         wait_not_busy();
         if (!rec.is_store) begin
            read_result(field_width(rec.f3), result);
            compare_word("o_rd", result, rec.expected);
         end
         close_test(i + 1, describe(rec), errors_before);
      end

      $display("%0d tests passed, %0d tests failed", pass_count, fail_count);
      if (fail_count == 0)
         $display("Testbench passed");
      else
         $display("Testbench failed");
      $finish;
   end

   // *******************************************************************
   // Watchdog

   initial begin
      int limit;
      wait (records_loaded);
      limit = records.size() * OP_CYCLES + RESET_CYCLES + 16;
      #(limit * CLK_PERIOD);
      $display("Timeout: the run did not finish within %0d clock cycles", limit);
      $display("Testbench failed");
      $finish;
   end

endmodule

`default_nettype wire

//--- tests/lsu_testdata.txt
# store(1)/load(0)  funct3  rs1  imm  rs2  expected load result, all in hex
# The expected column is ignored on stores
1 2 00000100 00000000 deadbeef 00000000
0 2 000000fc 00000004 00000000 deadbeef
1 2 0ffffffc 00000008 12345678 00000000
0 2 10000104 ffffff00 00000000 12345678
1 2 00000300 fffffff0 cafef00d 00000000
0 2 000002e0 00000010 00000000 cafef00d
1 2 7fffffff 00000001 a5a55a5a 00000000
0 2 80000010 fffffff0 00000000 a5a55a5a
1 2 00000200 00000000 11223344 00000000
1 0 00000200 00000000 000000aa 00000000
1 0 00000201 00000000 123456bb 00000000
0 2 00000100 00000100 00000000 1122bbaa
1 0 000001f0 00000012 000000cc 00000000
1 0 00000210 fffffff3 876543dd 00000000
0 2 00000210 fffffff0 00000000 ddccbbaa
1 2 00000340 00000000 8c7af05e 00000000
0 0 00000340 00000000 00000000 0000005e
0 0 00000331 00000010 00000000 fffffff0
0 0 00000350 fffffff2 00000000 0000007a
0 0 00000353 fffffff0 00000000 ffffff8c
0 4 00000340 00000000 00000000 0000005e
0 4 00000341 00000000 00000000 000000f0
0 4 00000342 00000000 00000000 0000007a
0 4 000002ff 00000044 00000000 0000008c
0 1 00000340 00000000 00000000 fffff05e
0 1 00000300 00000042 00000000 ffff8c7a
0 5 00000340 00000000 00000000 0000f05e
0 5 00000342 00000000 00000000 00008c7a
1 1 00000344 00000000 abcd6a85 00000000
1 1 00000340 00000006 00007f31 00000000
0 1 00000344 00000000 00000000 00006a85
0 1 00000346 00000000 00000000 00007f31
0 5 00000356 fffffff0 00000000 00007f31
0 2 00000344 00000000 00000000 7f316a85
